//--- Bender.yml
package:
  name: ahbl_sbus_sys

sources:
  - ahbl_pkg.sv
  - sbus_pkg.sv
  - sbus_ahbl_bridge.sv
  - ahbl_master_checker.sv
  - ahbl_slave_checker.sv
  - ahbl_sbus_sys.sv
  - target: simulation
    files:
      - tb_ahbl_mem.sv
      - tb_ahbl_sbus_sys.sv

//--- ahbl_master_checker.sv
/* AHB-Lite master checker. Flags malformed requests on sticky
   violation bits that hold until reset. */
`timescale 1ns/10ps

module ahbl_master_checker (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  ahbl_pkg::ahbl_req_t  i_req,
	input  ahbl_pkg::ahbl_rsp_t  i_rsp,
	output ahbl_pkg::ahbl_viol_t o_viol
);

logic                 active;
logic                 in_burst;
logic                 burst_q;
logic                 stall_q;
ahbl_pkg::ahbl_req_t  req_q;
ahbl_pkg::ahbl_viol_t hit;
ahbl_pkg::ahbl_viol_t hit_q;
ahbl_pkg::ahbl_viol_t viol_q;

// An address phase proper, BUSY carries no new transfer.
assign active = (i_req.htrans == ahbl_pkg::NONSEQ) || (i_req.htrans == ahbl_pkg::SEQ);

assign in_burst = (i_req.htrans == ahbl_pkg::BUSY) || (i_req.htrans == ahbl_pkg::SEQ);

// ##########################################################################
// Rules

always_comb begin
	hit = '0;
	case (i_req.hsize)
		ahbl_pkg::AHBL_SIZE_HALF: hit.mst_misalign = active && i_req.haddr[0];
		ahbl_pkg::AHBL_SIZE_WORD: hit.mst_misalign = active && (|i_req.haddr[1:0]);
		default:                  hit.mst_misalign = 1'b0;
	endcase
	hit.mst_size     = active && (i_req.hsize > ahbl_pkg::AHBL_SIZE_WORD);
	hit.mst_burst    = in_burst && !burst_q;
	hit.mst_unstable = stall_q && (i_req != req_q);
end

// ##########################################################################
// History

always_ff @(posedge clk) begin
	req_q <= i_req;
end

always_ff @(posedge clk) begin
	if (!i_rst_n) begin
		burst_q <= 1'b0;
		stall_q <= 1'b0;
	end else begin
		// Master may drop a stalled transfer once an error starts.
		stall_q <= active && !i_rsp.hready && !i_rsp.hresp;
		if (i_rsp.hready) begin
			case (i_req.htrans)
				ahbl_pkg::NONSEQ: burst_q <= (i_req.hburst != ahbl_pkg::AHBL_HBURST_SINGLE);
				ahbl_pkg::IDLE:   burst_q <= 1'b0;
				default:          burst_q <= burst_q; // Burst carries on.
			endcase
		end
	end
end

// Hits register first, then fold into the sticky flags.
always_ff @(posedge clk) begin
	if (!i_rst_n) begin
		hit_q  <= '0;
		viol_q <= '0;
	end else begin
		hit_q  <= hit;
		viol_q <= viol_q | hit_q;
	end
end

assign o_viol = viol_q;

endmodule

//--- ahbl_pkg.sv
/* AHB-Lite definitions: bus widths, transfer and size encodings,
   request and response payloads, and checker violation flags. */
package ahbl_pkg;

typedef logic [31:0] ahbl_addr_t;
typedef logic [31:0] ahbl_data_t;
typedef logic [2:0]  ahbl_size_t;
typedef logic [2:0]  ahbl_burst_t;
typedef logic [3:0]  ahbl_prot_t;

typedef enum logic [1:0] {
	IDLE   = 2'b00,
	BUSY   = 2'b01,
	NONSEQ = 2'b10,
	SEQ    = 2'b11
} ahbl_trans_e;

localparam ahbl_size_t  AHBL_SIZE_BYTE     = 3'd0;
localparam ahbl_size_t  AHBL_SIZE_HALF     = 3'd1;
localparam ahbl_size_t  AHBL_SIZE_WORD     = 3'd2;
localparam ahbl_burst_t AHBL_HBURST_SINGLE = 3'b000;
localparam ahbl_prot_t  AHBL_HPROT_DATA    = 4'b0011; // Data, privileged, no cache or buffer.

// Longest allowed run of wait states, 0 means no limit.
localparam int AHBL_MAX_STALL   = 16;
localparam int AHBL_STALL_CNT_W = $clog2(AHBL_MAX_STALL + 2);

typedef logic [AHBL_STALL_CNT_W-1:0] ahbl_stall_cnt_t;

typedef struct packed {
	ahbl_addr_t  haddr;
	logic        hwrite;
	ahbl_trans_e htrans;
	ahbl_size_t  hsize;
	ahbl_burst_t hburst;
	ahbl_prot_t  hprot;
	logic        hmastlock;
} ahbl_req_t;

typedef struct packed {
	logic hready;
	logic hresp;
} ahbl_rsp_t;

typedef struct packed {
	logic mst_misalign;   // Address not aligned to hsize.
	logic mst_size;       // hsize above a word.
	logic mst_burst;      // BUSY or SEQ outside a burst.
	logic mst_unstable;   // Request changed during a wait state.
	logic slv_idle_rsp;   // Wait or error with no data phase pending.
	logic slv_err_first;  // Error without its hready-low cycle.
	logic slv_err_second; // First error cycle not completed.
	logic slv_stall;      // Wait states past AHBL_MAX_STALL.
} ahbl_viol_t;

endpackage

//--- ahbl_sbus_sys.f
ahbl_pkg.sv
sbus_pkg.sv
sbus_ahbl_bridge.sv
ahbl_master_checker.sv
ahbl_slave_checker.sv
ahbl_sbus_sys.sv
tb_ahbl_mem.sv
tb_ahbl_sbus_sys.sv

//--- ahbl_sbus_sys.sv
/* Debug system-bus subsystem: bridge onto AHB-Lite with master
   and slave protocol checkers on the bus. */
`timescale 1ns/10ps

module ahbl_sbus_sys (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic                 i_sbus_vld,
	input  sbus_pkg::sbus_req_t  i_sbus_req,
	output logic                 o_sbus_rdy,
	output sbus_pkg::sbus_rsp_t  o_sbus_rsp,
	output ahbl_pkg::ahbl_req_t  o_ahbl_req,
	output ahbl_pkg::ahbl_data_t o_ahbl_hwdata,
	input  ahbl_pkg::ahbl_rsp_t  i_ahbl_rsp,
	input  ahbl_pkg::ahbl_data_t i_ahbl_hrdata,
	output ahbl_pkg::ahbl_viol_t o_mst_viol,
	output ahbl_pkg::ahbl_viol_t o_slv_viol
);

sbus_ahbl_bridge bridge_i (
	.clk           (clk),
	.i_rst_n       (i_rst_n),
	.i_sbus_vld    (i_sbus_vld),
	.i_sbus_req    (i_sbus_req),
	.o_sbus_rdy    (o_sbus_rdy),
	.o_sbus_rsp    (o_sbus_rsp),
	.o_ahbl_req    (o_ahbl_req),
	.o_ahbl_hwdata (o_ahbl_hwdata),
	.i_ahbl_rsp    (i_ahbl_rsp),
	.i_ahbl_hrdata (i_ahbl_hrdata)
);

// Both checkers watch the same bus.
ahbl_master_checker mst_checker_i (
	.clk     (clk),
	.i_rst_n (i_rst_n),
	.i_req   (o_ahbl_req),
	.i_rsp   (i_ahbl_rsp),
	.o_viol  (o_mst_viol)
);

ahbl_slave_checker slv_checker_i (
	.clk     (clk),
	.i_rst_n (i_rst_n),
	.i_req   (o_ahbl_req),
	.i_rsp   (i_ahbl_rsp),
	.o_viol  (o_slv_viol)
);

endmodule

//--- ahbl_slave_checker.sv
/* AHB-Lite slave checker. Tracks the pending data phase and flags
   malformed responses on sticky violation bits. */
`timescale 1ns/10ps

module ahbl_slave_checker (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  ahbl_pkg::ahbl_req_t  i_req,
	input  ahbl_pkg::ahbl_rsp_t  i_rsp,
	output ahbl_pkg::ahbl_viol_t o_viol
);

logic                      active;
logic                      pending_q;
logic                      err1_q;
ahbl_pkg::ahbl_stall_cnt_t stall_cnt;
ahbl_pkg::ahbl_viol_t      hit;
ahbl_pkg::ahbl_viol_t      hit_q;
ahbl_pkg::ahbl_viol_t      viol_q;

assign active = (i_req.htrans == ahbl_pkg::NONSEQ) || (i_req.htrans == ahbl_pkg::SEQ);

// ##########################################################################
// Rules

always_comb begin
	hit = '0;
	hit.slv_idle_rsp   = !pending_q && (!i_rsp.hready || i_rsp.hresp);
	hit.slv_err_first  = pending_q && i_rsp.hresp && i_rsp.hready && !err1_q;
	hit.slv_err_second = err1_q && !(i_rsp.hresp && i_rsp.hready);
	hit.slv_stall      = (ahbl_pkg::AHBL_MAX_STALL != 0) && pending_q && !i_rsp.hready
		&& (stall_cnt >= ahbl_pkg::AHBL_MAX_STALL);
end

// ##########################################################################
// Data phase tracking

always_ff @(posedge clk) begin
	if (!i_rst_n) begin
		pending_q <= 1'b0;
		err1_q    <= 1'b0;
		stall_cnt <= '0;
	end else begin
		if (i_rsp.hready)
			pending_q <= active; // Address phase accepted.
		err1_q <= pending_q && i_rsp.hresp && !i_rsp.hready;
		if (!pending_q || i_rsp.hready)
			stall_cnt <= '0;
		else if (stall_cnt < ahbl_pkg::AHBL_MAX_STALL)
			stall_cnt <= stall_cnt + 1'b1; // Saturates at the limit.
	end
end

always_ff @(posedge clk) begin
	if (!i_rst_n) begin
		hit_q  <= '0;
		viol_q <= '0;
	end else begin
		hit_q  <= hit;
		viol_q <= viol_q | hit_q;
	end
end

assign o_viol = viol_q;

endmodule

//--- sbus_ahbl_bridge.sv
/* Debug system-bus to AHB-Lite bridge. Each legal request becomes
   one single NONSEQ transfer; illegal ones are answered locally. */
`timescale 1ns/10ps

module sbus_ahbl_bridge (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic                 i_sbus_vld,
	input  sbus_pkg::sbus_req_t  i_sbus_req,
	output logic                 o_sbus_rdy,
	output sbus_pkg::sbus_rsp_t  o_sbus_rsp,
	output ahbl_pkg::ahbl_req_t  o_ahbl_req,
	output ahbl_pkg::ahbl_data_t o_ahbl_hwdata,
	input  ahbl_pkg::ahbl_rsp_t  i_ahbl_rsp,
	input  ahbl_pkg::ahbl_data_t i_ahbl_hrdata
);

typedef enum logic [1:0] {
	IDLE,
	ADDR,
	DATA,
	RESP
} state_e;

state_e               state;
logic                 misalign;
logic                 req_ok;
ahbl_pkg::ahbl_req_t  ctl_q;
ahbl_pkg::ahbl_data_t wdata_q;
ahbl_pkg::ahbl_data_t rd_shift;
ahbl_pkg::ahbl_data_t rd_data;
sbus_pkg::sbus_rsp_t  rsp_q;

// ##########################################################################
// Request check

always_comb begin
	case (i_sbus_req.size)
		sbus_pkg::SBUS_SIZE_HALF: misalign = i_sbus_req.addr[0];
		sbus_pkg::SBUS_SIZE_WORD: misalign = |i_sbus_req.addr[1:0];
		default:                  misalign = 1'b0;
	endcase
end

assign req_ok = (i_sbus_req.size != sbus_pkg::SBUS_SIZE_ILLEGAL) && !misalign;

// ##########################################################################
// Transfer FSM

always_ff @(posedge clk) begin
	if (!i_rst_n) begin
		state <= IDLE;
		ctl_q <= '0; // htrans comes out of reset as IDLE.
	end else begin
		case (state)
			IDLE: begin
				if (i_sbus_vld && req_ok) begin
					state           <= ADDR;
					ctl_q.haddr     <= i_sbus_req.addr;
					ctl_q.hwrite    <= i_sbus_req.write;
					ctl_q.htrans    <= ahbl_pkg::NONSEQ;
					ctl_q.hsize     <= {1'b0, i_sbus_req.size};
					ctl_q.hburst    <= ahbl_pkg::AHBL_HBURST_SINGLE;
					ctl_q.hprot     <= ahbl_pkg::AHBL_HPROT_DATA;
					ctl_q.hmastlock <= 1'b0;
				end else if (i_sbus_vld) begin
					state <= RESP; // Rejected, never reaches the bus.
				end
			end
			ADDR: begin
				if (i_ahbl_rsp.hready) begin
					state        <= DATA;
					ctl_q.htrans <= ahbl_pkg::IDLE;
				end
			end
			DATA: begin
				if (i_ahbl_rsp.hready)
					state <= RESP;
			end
			default: state <= IDLE;
		endcase
	end
end

// Read data comes back on the byte lanes of the address.
always_comb begin
	rd_shift = i_ahbl_hrdata >> {ctl_q.haddr[1:0], 3'b000};
	case (ctl_q.hsize)
		ahbl_pkg::AHBL_SIZE_BYTE: rd_data = {24'h0, rd_shift[7:0]};
		ahbl_pkg::AHBL_SIZE_HALF: rd_data = {16'h0, rd_shift[15:0]};
		default:                  rd_data = rd_shift;
	endcase
end

always_ff @(posedge clk) begin
	if (state == IDLE && i_sbus_vld) begin
		case (i_sbus_req.size)
			sbus_pkg::SBUS_SIZE_BYTE: wdata_q <= {4{i_sbus_req.wdata[7:0]}};
			sbus_pkg::SBUS_SIZE_HALF: wdata_q <= {2{i_sbus_req.wdata[15:0]}};
			default:                  wdata_q <= i_sbus_req.wdata;
		endcase
		rsp_q.err   <= !req_ok;
		rsp_q.rdata <= '0;
	end else if (state == DATA && i_ahbl_rsp.hready) begin
		rsp_q.err   <= i_ahbl_rsp.hresp; // Second error cycle.
		rsp_q.rdata <= ctl_q.hwrite ? '0 : rd_data;
	end
end

assign o_sbus_rdy    = (state == RESP);
assign o_sbus_rsp    = rsp_q;
assign o_ahbl_req    = ctl_q;
assign o_ahbl_hwdata = wdata_q;

endmodule

//--- sbus_pkg.sv
/* Debug system-bus definitions. Sub-word data is right-aligned
   in wdata and rdata. */
package sbus_pkg;

typedef logic [31:0] sbus_addr_t;
typedef logic [31:0] sbus_data_t;
typedef logic [1:0]  sbus_size_t;

localparam sbus_size_t SBUS_SIZE_BYTE    = 2'd0;
localparam sbus_size_t SBUS_SIZE_HALF    = 2'd1;
localparam sbus_size_t SBUS_SIZE_WORD    = 2'd2;
localparam sbus_size_t SBUS_SIZE_ILLEGAL = 2'd3;

typedef struct packed {
	sbus_addr_t addr;
	logic       write;
	sbus_size_t size;
	sbus_data_t wdata;
} sbus_req_t;

typedef struct packed {
	logic       err;
	sbus_data_t rdata; // Zero for writes and rejected requests.
} sbus_rsp_t;

endpackage

//--- tb_ahbl_mem.sv
/* Testbench AHB-Lite memory of 1 KiB with random wait states, an error region
   from 0xE000_0000 up, and injection of slave protocol faults. */
`timescale 1ns/10ps

module tb_ahbl_mem (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  ahbl_pkg::ahbl_req_t  i_req,
	input  ahbl_pkg::ahbl_data_t i_hwdata,
	input  logic                 i_no_wait,
	input  logic [1:0]           i_fault, // 0 none, 1 short error, 2 long stall, 3 idle wait.
	output ahbl_pkg::ahbl_rsp_t  o_rsp,
	output ahbl_pkg::ahbl_data_t o_hrdata
);

logic [7:0]           mem [0:1023];
logic                 pend_q;
logic                 write_q;
logic                 err_q;
logic                 err1_q;
logic                 idle_done_q;
logic [3:0]           strb;
ahbl_pkg::ahbl_addr_t addr_q;
ahbl_pkg::ahbl_size_t size_q;
int unsigned          wait_q;

always_comb begin
	o_rsp.hready = 1'b1;
	o_rsp.hresp  = 1'b0;
	if (!pend_q)
		o_rsp.hready = !(i_fault == 2'd3 && !idle_done_q
			&& i_req.htrans == ahbl_pkg::NONSEQ); // One stray wait state.
	else if (wait_q != 0)
		o_rsp.hready = 1'b0;
	else if (err_q) begin
		o_rsp.hresp  = 1'b1;
		o_rsp.hready = (i_fault == 2'd1) || err1_q;
	end
end

always_comb begin
	case (size_q)
		ahbl_pkg::AHBL_SIZE_BYTE: strb = 4'b0001 << addr_q[1:0];
		ahbl_pkg::AHBL_SIZE_HALF: strb = addr_q[1] ? 4'b1100 : 4'b0011;
		default:                  strb = 4'b1111;
	endcase
end

assign o_hrdata = {mem[{addr_q[9:2], 2'd3}], mem[{addr_q[9:2], 2'd2}],
	mem[{addr_q[9:2], 2'd1}], mem[{addr_q[9:2], 2'd0}]};

// ##########################################################################
// Address and data phases

always_ff @(posedge clk) begin
	if (!i_rst_n) begin
		pend_q      <= 1'b0;
		err_q       <= 1'b0;
		err1_q      <= 1'b0;
		idle_done_q <= 1'b0;
		wait_q      <= 0;
	end else begin
		if (!pend_q && !o_rsp.hready)
			idle_done_q <= 1'b1;
		if (o_rsp.hready) begin
			pend_q  <= (i_req.htrans == ahbl_pkg::NONSEQ);
			addr_q  <= i_req.haddr;
			write_q <= i_req.hwrite;
			size_q  <= i_req.hsize;
			err_q   <= (i_req.haddr >= 32'hE000_0000);
			err1_q  <= 1'b0;
			if (i_fault == 2'd2)
				wait_q <= ahbl_pkg::AHBL_MAX_STALL + 2;
			else
				wait_q <= i_no_wait ? 0 : $urandom % 4;
		end else if (pend_q) begin
			if (wait_q != 0)
				wait_q <= wait_q - 1;
			else
				err1_q <= 1'b1; // First error cycle done.
		end
	end
end

always @(posedge clk) begin
	if (i_rst_n && pend_q && o_rsp.hready && write_q && !err_q) begin
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				mem[{addr_q[9:2], 2'(b)}] <= i_hwdata[8*b +: 8];
		end
	end
end

endmodule

//--- tb_ahbl_sbus_sys.sv
/* Testbench for the debug system-bus subsystem. Checks data against a byte
   model, bridge timing, bus errors and the slave checker fault modes. */
`timescale 1ns/10ps

module tb_ahbl_sbus_sys;

localparam int CLK_PERIOD   = 100;
localparam int N_PAIRS      = 24;
localparam int N_TXN        = 2 * N_PAIRS + 12;
localparam int ACCESS_LIMIT = 40;

logic                 clk;
logic                 rst_n;
logic                 sbus_vld;
sbus_pkg::sbus_req_t  sbus_req;
logic                 sbus_rdy;
sbus_pkg::sbus_rsp_t  sbus_rsp;
ahbl_pkg::ahbl_req_t  ahbl_req;
ahbl_pkg::ahbl_data_t hwdata;
ahbl_pkg::ahbl_rsp_t  ahbl_rsp;
ahbl_pkg::ahbl_data_t hrdata;
ahbl_pkg::ahbl_viol_t mst_viol;
ahbl_pkg::ahbl_viol_t slv_viol;
logic                 no_wait;
logic [1:0]           fault_mode;
logic                 expect_idle;
logic [7:0]           model_mem [0:1023];
int                   value_errors;
int                   protocol_errors;

ahbl_sbus_sys ahbl_sbus_sys_i (
	.clk           (clk),
	.i_rst_n       (rst_n),
	.i_sbus_vld    (sbus_vld),
	.i_sbus_req    (sbus_req),
	.o_sbus_rdy    (sbus_rdy),
	.o_sbus_rsp    (sbus_rsp),
	.o_ahbl_req    (ahbl_req),
	.o_ahbl_hwdata (hwdata),
	.i_ahbl_rsp    (ahbl_rsp),
	.i_ahbl_hrdata (hrdata),
	.o_mst_viol    (mst_viol),
	.o_slv_viol    (slv_viol)
);

tb_ahbl_mem mem_i (
	.clk       (clk),
	.i_rst_n   (rst_n),
	.i_req     (ahbl_req),
	.i_hwdata  (hwdata),
	.i_no_wait (no_wait),
	.i_fault   (fault_mode),
	.o_rsp     (ahbl_rsp),
	.o_hrdata  (hrdata)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
	#(N_TXN * ACCESS_LIMIT * CLK_PERIOD);
	$display("Watchdog expired, the tests did not finish in %0d cycles", N_TXN * ACCESS_LIMIT);
	$display("RESULT: FAIL");
	$finish;
end

// ##########################################################################
// Bus properties

task automatic protocol_fail(input string msg);
	protocol_errors++;
	$display("Protocol error at %0t: %s", $time, msg);
endtask

mst_clean_a: assert property (@(posedge clk) disable iff (!rst_n) mst_viol == '0)
	else protocol_fail("master checker flagged the bridge traffic");
req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
	(ahbl_req.htrans != ahbl_pkg::IDLE && !ahbl_rsp.hready) |=> $stable(ahbl_req))
	else protocol_fail("AHB request changed during a wait state");
slv_clean_a: assert property (@(posedge clk) disable iff (!rst_n)
	(fault_mode == 2'd0) |-> slv_viol == '0)
	else protocol_fail("slave checker flagged legal memory responses");
idle_a: assert property (@(posedge clk) disable iff (!rst_n)
	expect_idle |-> ahbl_req.htrans == ahbl_pkg::IDLE)
	else protocol_fail("rejected request reached the AHB bus");

// ##########################################################################
// Stimulus tasks

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	assert (actual === expected)
	else begin
		value_errors++;
		$display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
	end
endtask

task automatic apply_reset(input logic [1:0] mode);
	@(posedge clk);
	#10;
	rst_n      = 1'b0;
	fault_mode = mode;
	repeat (4) @(posedge clk);
	#10;
	rst_n = 1'b1;
endtask

// Cycles are counted from the edge that accepts vld up to the rdy pulse.
task automatic sbus_access(input sbus_pkg::sbus_addr_t addr, input logic write,
	input sbus_pkg::sbus_size_t size, input sbus_pkg::sbus_data_t wdata,
	output sbus_pkg::sbus_rsp_t rsp, output int cycles);
	cycles = 0;
	@(posedge clk);
	#10;
	sbus_vld = 1'b1;
	sbus_req = '{addr: addr, write: write, size: size, wdata: wdata};
	do begin
		@(posedge clk);
		#1;
		cycles++;
	end while (!sbus_rdy && cycles < ACCESS_LIMIT);
	rsp = sbus_rsp;
	if (!sbus_rdy)
		protocol_fail("bridge gave no rdy for a request");
	#9;
	sbus_vld = 1'b0;
endtask

task automatic write_read_pair();
	sbus_pkg::sbus_size_t size;
	sbus_pkg::sbus_addr_t addr;
	sbus_pkg::sbus_data_t wdata;
	sbus_pkg::sbus_data_t expected;
	sbus_pkg::sbus_rsp_t  rsp;
	int                   cycles;
	size     = sbus_pkg::sbus_size_t'($urandom % 3);
	addr     = ($urandom % 1024) & ~((32'd1 << size) - 1);
	wdata    = $urandom;
	expected = '0;
	for (int b = 0; b < (1 << size); b++) begin
		model_mem[addr + b] = wdata[8*b +: 8];
		expected[8*b +: 8]  = model_mem[addr + b];
	end
	sbus_access(addr, 1'b1, size, wdata, rsp, cycles);
	check_value("write_err", 0, rsp.err);
	sbus_access(addr, 1'b0, size, 32'h0, rsp, cycles);
	check_value("read_err", 0, rsp.err);
	check_value("read_data", expected, rsp.rdata);
endtask

task automatic reject_test(input string name, input sbus_pkg::sbus_addr_t addr,
	input sbus_pkg::sbus_size_t size);
	sbus_pkg::sbus_rsp_t rsp;
	int                  cycles;
	expect_idle = 1'b1;
	sbus_access(addr, 1'b0, size, 32'h0, rsp, cycles);
	repeat (2) @(posedge clk); // Bus stays idle after the reply as well.
	#10;
	expect_idle = 1'b0;
	check_value({name, "_latency"}, 1, cycles);
	check_value({name, "_err"}, 1, rsp.err);
endtask

task automatic fault_test(input logic [1:0] mode, input sbus_pkg::sbus_addr_t addr,
	input logic exp_err, input ahbl_pkg::ahbl_viol_t exp_viol);
	sbus_pkg::sbus_rsp_t rsp;
	int                  cycles;
	apply_reset(mode);
	sbus_access(addr, 1'b1, sbus_pkg::SBUS_SIZE_WORD, 32'hC0DE_0000 | mode, rsp, cycles);
	check_value($sformatf("fault%0d_err", mode), exp_err, rsp.err);
	repeat (2) @(posedge clk);
	#1;
	check_value($sformatf("fault%0d_viol", mode), exp_viol, slv_viol);
	repeat (4) @(posedge clk);
	#1;
	check_value($sformatf("fault%0d_viol_hold", mode), exp_viol, slv_viol);
endtask

// ##########################################################################
// Test sequence

initial begin
	sbus_pkg::sbus_rsp_t  rsp;
	int                   cycles;
	ahbl_pkg::ahbl_viol_t viol;
	void'($urandom(71842));
	value_errors    = 0;
	protocol_errors = 0;
	rst_n           = 1'b0;
	sbus_vld        = 1'b0;
	sbus_req        = '0;
	no_wait         = 1'b0;
	fault_mode      = 2'd0;
	expect_idle     = 1'b0;
	repeat (4) @(posedge clk);
	#10;
	rst_n = 1'b1;

	repeat (N_PAIRS) write_read_pair();

	no_wait = 1'b1; // Zero wait states for the latency checks.
	sbus_access(32'h100, 1'b1, sbus_pkg::SBUS_SIZE_WORD, 32'h1234_5678, rsp, cycles);
	check_value("legal_latency", 3, cycles);
	reject_test("size3", 32'h104, sbus_pkg::SBUS_SIZE_ILLEGAL);
	reject_test("misalign_half", 32'h103, sbus_pkg::SBUS_SIZE_HALF);
	reject_test("misalign_word", 32'h106, sbus_pkg::SBUS_SIZE_WORD);
	no_wait = 1'b0;

	sbus_access(32'hE000_0100, 1'b1, sbus_pkg::SBUS_SIZE_WORD, 32'hDEAD_BEEF, rsp, cycles);
	check_value("errregion_write_err", 1, rsp.err);
	sbus_access(32'hE000_0100, 1'b0, sbus_pkg::SBUS_SIZE_WORD, 32'h0, rsp, cycles);
	check_value("errregion_read_err", 1, rsp.err);
	repeat (2) @(posedge clk);
	#1;
	check_value("errregion_slv_viol", 0, slv_viol);

	viol = '0;
	viol.slv_err_first = 1'b1;
	fault_test(2'd1, 32'hE000_0040, 1'b1, viol);
	viol = '0;
	viol.slv_stall = 1'b1;
	fault_test(2'd2, 32'h200, 1'b0, viol);
	viol = '0;
	viol.slv_idle_rsp = 1'b1;
	fault_test(2'd3, 32'h204, 1'b0, viol);

	$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
	if (value_errors + protocol_errors == 0)
		$display("RESULT: PASS");
	else
		$display("RESULT: FAIL");
	$finish;
end

endmodule
